/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// a store to this word ends a test program
`define HALT_ADDR 32'h0000_0FFC

`endif

/* src/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    typedef logic [31:0] rv32i_word; // data or address
    typedef logic [4:0]  rv32i_reg;  // register index

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011, // beq, bne
        op_load  = 7'b0000011, // lw only
        op_store = 7'b0100011, // sw, sb
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b // lui
    } alu_ops;

endpackage : rv32i_types_pkg

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one enable bit per byte lane, also used as wishbone sel
    typedef logic [3:0] byte_mask;

    // bridge transfer state
    typedef enum logic [1:0] {
        idle,
        instr_cycle, // serving port a
        data_cycle   // serving port b
    } bridge_state;

endpackage : mem_bus_pkg

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv32i_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    input  rv32i_reg  rd,
    input  logic      load,
    input  rv32i_word in,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    rv32i_word data [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (load && (rd != 5'd0)) begin // x0 stays zero
            data[rd] <= in;
        end
    end

    // asynchronous read
    assign reg_a = data[rs1];
    assign reg_b = data[rs2];

endmodule : reg_file

/* src/alu.sv */
`timescale 1ns/10ps

module alu import rv32i_types_pkg::*; (
    input  alu_ops    aluop,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f,
    output logic      eq
);

    always_comb begin
        case (aluop)
            alu_add:    f = a + b;
            alu_sub:    f = a - b;
            alu_and:    f = a & b;
            alu_or:     f = a | b;
            alu_xor:    f = a ^ b;
            alu_pass_b: f = b;
            default:    f = a + b;
        endcase
    end

    // beq / bne compare rs1 with rs2
    assign eq = (a == b);

endmodule : alu

/* src/cpu_core.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_core import rv32i_types_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // instruction port
    output logic      read_a,
    output rv32i_word address_a,
    input  logic      resp_a,
    input  rv32i_word rdata_a,

    // data port
    output logic      read_b,
    output logic      write_b,
    output byte_mask  wmask_b,
    output rv32i_word address_b,
    output rv32i_word wdata_b,
    input  logic      resp_b,
    input  rv32i_word rdata_b
);

    // fetch side
    rv32i_word pc;          // next fetch address
    logic      hold_valid;
    rv32i_word hold_instr;
    rv32i_word hold_pc;
    logic      drop;        // in-flight fetch is stale after a flush
    logic      start_fetch;
    logic      fetch_valid;
    rv32i_word fetch_word;
    rv32i_word fetch_pc;

    // execute side
    rv32i_word   ex_instr;
    rv32i_word   ex_pc;
    logic        b_gap;     // request low for one cycle after resp_b
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    rv32i_reg    rs1, rs2, rd;
    rv32i_word   i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32i_word   rs1_val, rs2_val;
    rv32i_word   alu_b, alu_f;
    rv32i_word   wb_data;
    rv32i_word   target;
    alu_ops      aluop;
    logic        eq;
    logic        is_load, is_store;
    logic        writes_rd;
    logic        rf_load;
    logic        taken;
    logic        flush;
    logic        ex_done;

    assign opcode = rv32i_opcode'(ex_instr[6:0]);
    assign funct3 = ex_instr[14:12];
    assign rs1    = ex_instr[19:15];
    assign rs2    = ex_instr[24:20];
    assign rd     = ex_instr[11:7];

    assign i_imm = {{21{ex_instr[31]}}, ex_instr[30:20]};
    assign s_imm = {{21{ex_instr[31]}}, ex_instr[30:25], ex_instr[11:7]};
    assign b_imm = {{20{ex_instr[31]}}, ex_instr[7], ex_instr[30:25], ex_instr[11:8], 1'b0};
    assign u_imm = {ex_instr[31:12], 12'h000};
    assign j_imm = {{12{ex_instr[31]}}, ex_instr[19:12], ex_instr[20], ex_instr[30:21], 1'b0};

    // decode
    always_comb begin
        aluop     = alu_add;
        alu_b     = i_imm;
        writes_rd = 1'b0;
        case (opcode)
            op_lui: begin
                aluop     = alu_pass_b;
                alu_b     = u_imm;
                writes_rd = 1'b1;
            end
            op_jal:   writes_rd = 1'b1;
            op_br:    alu_b = rs2_val;
            op_load:  writes_rd = 1'b1;
            op_store: alu_b = s_imm; // address = rs1 + s_imm
            op_imm, op_reg: begin
                writes_rd = 1'b1;
                if (opcode == op_reg) begin
                    alu_b = rs2_val;
                end
                case (funct3)
                    3'b111:  aluop = alu_and;
                    3'b110:  aluop = alu_or;
                    3'b100:  aluop = alu_xor;
                    default: aluop = (opcode == op_reg && ex_instr[30]) ? alu_sub : alu_add;
                endcase
            end
            default: ; // unsupported opcode runs as a nop
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal:  wb_data = ex_pc + 32'd4; // link
            op_load: wb_data = rdata_b;
            default: wb_data = alu_f;
        endcase
    end

    assign is_load  = (opcode == op_load);
    assign is_store = (opcode == op_store);
    assign ex_done  = ~(is_load | is_store) | resp_b;
    assign rf_load  = writes_rd & ex_done;

    assign taken  = (opcode == op_br) & ((funct3 == 3'b000) ? eq : ((funct3 == 3'b001) & ~eq));
    assign flush  = taken | (opcode == op_jal);
    assign target = ex_pc + ((opcode == op_jal) ? j_imm : b_imm);

    // data port, held steady while execute waits
    assign read_b    = is_load & ~b_gap;
    assign write_b   = is_store & ~b_gap;
    assign address_b = alu_f;
    assign wmask_b   = (funct3 == 3'b000) ? byte_mask'(4'b0001 << alu_f[1:0]) : 4'b1111;
    assign wdata_b   = (funct3 == 3'b000) ? (rv32i_word'(rs2_val[7:0]) << {alu_f[1:0], 3'b000})
                                          : rs2_val;

    // fetched word comes from the hold register or straight off port a
    assign fetch_valid = hold_valid | (resp_a & ~drop);
    assign fetch_word  = hold_valid ? hold_instr : rdata_a;
    assign fetch_pc    = hold_valid ? hold_pc : address_a;
    assign start_fetch = ~read_a & ~hold_valid & ~flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `RESET_PC;
            read_a     <= 1'b0;
            hold_valid <= 1'b0;
            drop       <= 1'b0;
            ex_instr   <= `NOP_INSTR;
            b_gap      <= 1'b0;
        end else begin
            b_gap <= resp_b;

            if (resp_a) begin
                read_a <= 1'b0;
                drop   <= 1'b0;
            end else if (start_fetch) begin
                read_a    <= 1'b1;
                address_a <= pc;
                pc        <= pc + 32'd4;
            end

            if (ex_done) begin
                if (flush) begin
                    // static not-taken, squash what was fetched behind us
                    ex_instr   <= `NOP_INSTR;
                    hold_valid <= 1'b0;
                    pc         <= target;
                    drop       <= read_a & ~resp_a;
                end else if (fetch_valid) begin
                    ex_instr   <= fetch_word;
                    ex_pc      <= fetch_pc;
                    hold_valid <= 1'b0;
                end else begin
                    ex_instr <= `NOP_INSTR; // bubble
                end
            end else if (resp_a & ~drop) begin
                hold_valid <= 1'b1; // execute busy, park the word
                hold_instr <= rdata_a;
                hold_pc    <= address_a;
            end
        end
    end

    reg_file regfile (
        .clk,
        .rst,
        .rs1,
        .rs2,
        .rd,
        .load  (rf_load),
        .in    (wb_data),
        .reg_a (rs1_val),
        .reg_b (rs2_val)
    );

    alu alu (
        .aluop,
        .a  (rs1_val),
        .b  (alu_b),
        .f  (alu_f),
        .eq
    );

endmodule : cpu_core

/* src/wb_bridge.sv */
`timescale 1ns/10ps

module wb_bridge import rv32i_types_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // core instruction port
    input  logic      read_a,
    input  rv32i_word address_a,
    output logic      resp_a,
    output rv32i_word rdata_a,

    // core data port
    input  logic      read_b,
    input  logic      write_b,
    input  byte_mask  wmask_b,
    input  rv32i_word address_b,
    input  rv32i_word wdata_b,
    output logic      resp_b,
    output rv32i_word rdata_b,

    // wishbone classic master
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output rv32i_word wb_adr,
    output rv32i_word wb_dat_w,
    output byte_mask  wb_sel,
    input  logic      wb_ack,
    input  rv32i_word wb_dat_r
);

    bridge_state state;
    logic        grant_a, grant_b;

    // data port wins a tie
    assign grant_b = (state == idle) & (read_b | write_b);
    assign grant_a = (state == idle) & read_a & ~(read_b | write_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (grant_b) begin
                        state <= data_cycle;
                    end else if (grant_a) begin
                        state <= instr_cycle;
                    end
                end
                instr_cycle, data_cycle: begin
                    if (wb_ack) begin
                        state <= idle; // cyc drops next cycle
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // transfer latch, loaded only when leaving idle
    always_ff @(posedge clk) begin
        if (grant_b) begin
            wb_adr   <= address_b;
            wb_we    <= write_b;
            wb_dat_w <= wdata_b;
            wb_sel   <= write_b ? wmask_b : 4'b1111;
        end else if (grant_a) begin
            wb_adr <= address_a;
            wb_we  <= 1'b0;
            wb_sel <= 4'b1111; // whole word fetch
        end
    end

    assign wb_cyc = (state != idle);
    assign wb_stb = (state != idle);

    // ack goes straight back to the port being served
    assign resp_a  = (state == instr_cycle) & wb_ack;
    assign resp_b  = (state == data_cycle) & wb_ack;
    assign rdata_a = wb_dat_r;
    assign rdata_b = wb_dat_r;

endmodule : wb_bridge

/* src/soc_top.sv */
`timescale 1ns/10ps

module soc_top import rv32i_types_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output rv32i_word wb_adr,
    output rv32i_word wb_dat_w,
    output byte_mask  wb_sel,
    input  logic      wb_ack,
    input  rv32i_word wb_dat_r
);

    // port a, instruction fetch
    logic      read_a;
    rv32i_word address_a;
    logic      resp_a;
    rv32i_word rdata_a;

    // port b, loads and stores
    logic      read_b;
    logic      write_b;
    byte_mask  wmask_b;
    rv32i_word address_b;
    rv32i_word wdata_b;
    logic      resp_b;
    rv32i_word rdata_b;

    cpu_core core (
        .clk,
        .rst,
        .read_a,
        .address_a,
        .resp_a,
        .rdata_a,
        .read_b,
        .write_b,
        .wmask_b,
        .address_b,
        .wdata_b,
        .resp_b,
        .rdata_b
    );

    wb_bridge bridge (
        .clk,
        .rst,
        .read_a,
        .address_a,
        .resp_a,
        .rdata_a,
        .read_b,
        .write_b,
        .wmask_b,
        .address_b,
        .wdata_b,
        .resp_b,
        .rdata_b,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_sel,
        .wb_ack,
        .wb_dat_r
    );

endmodule : soc_top

/* test/soc_properties.sv */
`timescale 1ns/10ps

module soc_properties import rv32i_types_pkg::*, mem_bus_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input rv32i_word   wb_adr,
    input byte_mask    wb_sel,
    input logic        wb_ack,
    input logic        resp_a,
    input logic        resp_b
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wishbone stb high without cyc");

    // request fields frozen until the slave answers
    request_held: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_sel)))
        else $error("wishbone adr, we or sel changed before ack");

    one_resp: assert property (@(posedge clk) disable iff (rst) !(resp_a && resp_b))
        else $error("resp_a and resp_b high in the same cycle");

    cyc_drops: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_cyc)
        else $error("wishbone cyc still high the cycle after ack");

endmodule : soc_properties

/* test/tb_soc_top.sv */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module tb_soc_top
    import rv32i_types_pkg::*, mem_bus_pkg::*;
();

    localparam int MAX_CYCLES = 3000; // 5 tests x 40 instr x 12 cycles, plus margin

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      wb_cyc, wb_stb, wb_we;
    rv32i_word wb_adr, wb_dat_w;
    byte_mask  wb_sel;
    logic      wb_ack = 1'b0;
    rv32i_word wb_dat_r = '0;

    rv32i_word mem [1024];      // word addressed, byte address bits [11:2]
    int        load_ptr = 0;
    int        halt_count = 0;
    byte_mask  last_sel = '0;   // sel of the latest store below the halt word
    bit        wait_en = 1'b0;
    bit        busy = 1'b0;
    int        wait_left = 0;
    integer    seed = 14863;
    int        cycle_count = 0;

    soc_top uut (
        .clk,
        .rst,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_sel,
        .wb_ack,
        .wb_dat_r
    );

    bind wb_bridge soc_properties props (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_ack(wb_ack), .resp_a(resp_a), .resp_b(resp_b)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: program did not reach its halt store in %0d cycles", cycle_count);
            $display("*** FAILED ***");
            $fatal(1, "run stopped by timeout");
        end
    end

    // wishbone memory, answers on the falling edge
    always @(negedge clk) begin
        if (rst || wb_ack) begin
            wb_ack <= 1'b0; // one ack per transfer
            busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                // ack one cycle after stb, plus any wait states
                wait_left = wait_en ? 2 + ($unsigned($random(seed)) % 3) : 1;
            end
            if (wait_left != 0) begin
                wait_left--;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[11:2]];
                if (wb_we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_sel[i]) mem[wb_adr[11:2]][8*i +: 8] = wb_dat_w[8*i +: 8];
                    end
                    if (wb_adr == `HALT_ADDR) halt_count <= halt_count + 1;
                    else last_sel <= wb_sel;
                end
            end
        end
    end

    function automatic rv32i_word fill_value(int idx);
        return 32'hA5A5_0000 ^ rv32i_word'(idx * 4); // tied to the byte address
    endfunction

    // instruction encoders
    function automatic rv32i_word enc_i(rv32i_opcode op, rv32i_reg rd, logic [2:0] f3,
                                        rv32i_reg rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32i_word enc_r(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
                                        logic [2:0] f3, rv32i_reg rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic rv32i_word enc_s(rv32i_reg rs2, rv32i_reg rs1, logic [2:0] f3,
                                        logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic rv32i_word enc_b(rv32i_reg rs1, rv32i_reg rs2, logic [2:0] f3,
                                        logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
    endfunction

    function automatic rv32i_word enc_u(rv32i_reg rd, logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic rv32i_word enc_j(rv32i_reg rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    task automatic check_word(input string name, input rv32i_word expected,
                              input rv32i_word actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "memory word mismatch");
        end
    endtask

    task automatic check_sel(input string name, input byte_mask expected,
                             input byte_mask actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected sel %b, actual sel %b", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "byte select mismatch");
        end
    endtask

    task automatic emit(input rv32i_word instr);
        mem[load_ptr] = instr;
        load_ptr++;
    endtask

    task automatic emit_halt();
        emit(enc_u(5'd31, 20'h00001));              // x31 = 0x1000
        emit(enc_s(5'd0, 5'd31, 3'b010, 12'hFFC));  // sw x0, -4(x31)
        emit(enc_j(5'd0, 21'd0));                   // spin here
    endtask

    // hold reset and refill memory for a new program
    task automatic start_program(input bit waits);
        @(negedge clk);
        rst <= 1'b1;
        @(negedge clk);
        wait_en = waits;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_value(i);
        end
        load_ptr = 0;
    endtask

    task automatic run_program();
        int halts_before;
        halts_before = halt_count;
        repeat (3) @(negedge clk);
        rst <= 1'b0;
        while (halt_count == halts_before) @(negedge clk);
    endtask

    task automatic load_alu_program();
        rv32i_reg src [10];
        src = '{5'd1, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11};
        emit(enc_u(5'd1, 20'h12345));
        emit(enc_i(op_imm, 5'd2, 3'b000, 5'd0, 12'h678));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));     // add, uses both just written
        emit(enc_i(op_imm, 5'd4, 3'b000, 5'd3, 12'hFFF)); // addi -1
        emit(enc_i(op_imm, 5'd5, 3'b111, 5'd3, 12'h0F0));
        emit(enc_i(op_imm, 5'd6, 3'b110, 5'd2, 12'h700));
        emit(enc_i(op_imm, 5'd7, 3'b100, 5'd3, 12'hFFF));
        emit(enc_r(7'h20, 5'd3, 5'd2, 3'b000, 5'd8));     // sub x8 = x2 - x3
        emit(enc_r(7'h00, 5'd7, 5'd3, 3'b111, 5'd9));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd10));
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd11));
        for (int i = 0; i < 10; i++) begin
            emit(enc_s(src[i], 5'd0, 3'b010, 12'(32'h400 + 4 * i)));
        end
        emit_halt();
    endtask

    task automatic check_alu_results(input string name);
        rv32i_word r1, r2, r3, r4, r7;
        r1 = 32'h12345 << 12;
        r2 = 32'h678;
        r3 = r1 + r2;
        r4 = r3 - 32'd1;
        r7 = r3 ^ 32'hFFFF_FFFF; // xori with sign-extended 0xfff
        check_word({name, " lui"}, r1, mem[256]);
        check_word({name, " add"}, r3, mem[257]);
        check_word({name, " addi"}, r4, mem[258]);
        check_word({name, " andi"}, r3 & 32'h0F0, mem[259]);
        check_word({name, " ori"}, r2 | 32'h700, mem[260]);
        check_word({name, " xori"}, r7, mem[261]);
        check_word({name, " sub"}, r2 - r3, mem[262]);
        check_word({name, " and"}, r3 & r7, mem[263]);
        check_word({name, " or"}, r1 | r2, mem[264]);
        check_word({name, " xor"}, r4 ^ r3, mem[265]);
    endtask

    task automatic test_alu();
        start_program(1'b0);
        load_alu_program();
        run_program();
        check_alu_results("alu");
    endtask

    task automatic test_load_store();
        rv32i_word exp_word;
        start_program(1'b0);
        mem[320] = 32'hCAFE_BABE; // 0x500
        mem[321] = 32'h1122_3344; // 0x504
        emit(enc_i(op_load, 5'd1, 3'b010, 5'd0, 12'h500));
        emit(enc_s(5'd1, 5'd0, 3'b010, 12'h508));          // copy right after the load
        emit(enc_i(op_imm, 5'd2, 3'b000, 5'd0, 12'h0AB));
        emit(enc_s(5'd2, 5'd0, 3'b000, 12'h506));          // sb into lane 2
        emit_halt();
        run_program();
        exp_word = (32'h1122_3344 & ~32'h00FF_0000) | (32'h0000_00AB << 16);
        check_word("load_store copy", 32'hCAFE_BABE, mem[322]);
        check_word("load_store source", 32'hCAFE_BABE, mem[320]);
        check_word("load_store sb", exp_word, mem[321]);
        check_sel("load_store sb", 4'b0100, last_sel);
    endtask

    task automatic test_branches();
        start_program(1'b0);
        emit(enc_i(op_imm, 5'd1, 3'b000, 5'd0, 12'd5));  // 0x00
        emit(enc_i(op_imm, 5'd2, 3'b000, 5'd0, 12'd5));  // 0x04
        emit(enc_i(op_imm, 5'd3, 3'b000, 5'd0, 12'd7));  // 0x08
        emit(enc_b(5'd1, 5'd2, 3'b000, 13'd8));          // 0x0c beq taken
        emit(enc_s(5'd1, 5'd0, 3'b010, 12'h600));        // 0x10 skipped
        emit(enc_b(5'd1, 5'd3, 3'b001, 13'd8));          // 0x14 bne taken
        emit(enc_s(5'd1, 5'd0, 3'b010, 12'h604));        // 0x18 skipped
        emit(enc_b(5'd1, 5'd3, 3'b000, 13'd8));          // 0x1c beq falls through
        emit(enc_s(5'd3, 5'd0, 3'b010, 12'h608));        // 0x20
        emit(enc_b(5'd1, 5'd2, 3'b001, 13'd8));          // 0x24 bne falls through
        emit(enc_s(5'd2, 5'd0, 3'b010, 12'h60C));        // 0x28
        emit(enc_j(5'd5, 21'd8));                        // 0x2c jal x5
        emit(enc_s(5'd1, 5'd0, 3'b010, 12'h610));        // 0x30 skipped
        emit(enc_s(5'd5, 5'd0, 3'b010, 12'h614));        // 0x34
        emit_halt();
        run_program();
        check_word("beq taken", fill_value(384), mem[384]);
        check_word("bne taken", fill_value(385), mem[385]);
        check_word("beq not taken", 32'd7, mem[386]);
        check_word("bne not taken", 32'd5, mem[387]);
        check_word("jal skip", fill_value(388), mem[388]);
        check_word("jal link", 32'h2C + 32'd4, mem[389]);
    endtask

    task automatic test_x0();
        start_program(1'b0);
        emit(enc_i(op_imm, 5'd0, 3'b000, 5'd0, 12'h123));
        emit(enc_u(5'd0, 20'hFFFFF));
        emit(enc_s(5'd0, 5'd0, 3'b010, 12'h700));
        emit(enc_i(op_imm, 5'd1, 3'b000, 5'd0, 12'h055));  // x0 must read as zero
        emit(enc_s(5'd1, 5'd0, 3'b010, 12'h704));
        emit_halt();
        run_program();
        check_word("x0 store", 32'd0, mem[448]);
        check_word("x0 operand", 32'h55, mem[449]);
    endtask

    task automatic test_wait_states();
        start_program(1'b1);
        load_alu_program();
        run_program();
        check_alu_results("wait_states");
    endtask

    initial begin
        test_alu();
        test_load_store();
        test_branches();
        test_x0();
        test_wait_states();
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_soc_top

/* soc_top.f */
+incdir+src
src/rv32i_types_pkg.sv
src/mem_bus_pkg.sv
src/reg_file.sv
src/alu.sv
src/cpu_core.sv
src/wb_bridge.sv
src/soc_top.sv
test/soc_properties.sv
test/tb_soc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it, exit status tells pass or fail
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc_top -Mdir obj_dir -f soc_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_soc_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
